// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
LINTFLAGS := --lint-only --timing
TOP       := tb_a2_card_core
FILELIST  := a2_card_core.f
LOG       := sim.log
FAIL_MSG  := TEST RESULT: FAIL

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$status

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: a2_card_core.f
+incdir+test
design/a2_card_pkg.sv
design/bus_timing_if.sv
design/signal_denoise.sv
design/bus_clock_recovery.sv
design/card_bus_arbiter.sv
design/audio_mixer.sv
design/a2_card_core.sv
test/tb_a2_card_core.sv

// File: design/a2_card_core.sv
// Card glue top level with bus clock recovery, read arbitration and audio mixing
`timescale 1ns/10ps
`default_nettype none

module a2_card_core (
    input  logic clk_logic_w,
    input  logic arst_n_i,

    // Apple bus clocks and reset
    input  logic a2_phi1_i,
    input  logic a2_7m_i,
    input  logic a2_reset_n_i,

    // Card read strobes, data bytes packed with card 0 in the low byte
    input  logic [a2_card_pkg::CARD_COUNT-1:0]   card_rd_i,
    input  logic [a2_card_pkg::CARD_COUNT*8-1:0] card_data_i,
    input  logic [7:0]                            bus_data_i,
    input  logic [a2_card_pkg::IRQ_CARD_COUNT-1:0] card_irq_n_i,

    // Audio sources
    input  logic [15:0] ensoniq_l_i,
    input  logic [15:0] ensoniq_r_i,
    input  logic [a2_card_pkg::MB_SAMPLE_W-1:0] mb_l_i,
    input  logic [a2_card_pkg::MB_SAMPLE_W-1:0] mb_r_i,
    input  logic [15:0] sprite_i,
    input  logic speaker_i,
    input  logic speaker_en_i,

    output logic system_reset_n_o,
    output logic data_out_en_o,
    output logic [7:0] data_out_o,
    output logic irq_n_o,
    output logic [15:0] audio_l_o,
    output logic [15:0] audio_r_o,
    output logic audio_strobe_o
);

    logic system_reset_n;

    bus_timing_if timing_if ();

    bus_clock_recovery u_clock_recovery (
        .clk_logic_w      (clk_logic_w),
        .arst_n_i         (arst_n_i),
        .a2_phi1_i        (a2_phi1_i),
        .a2_7m_i          (a2_7m_i),
        .a2_reset_n_i     (a2_reset_n_i),
        .timing           (timing_if.source),
        .system_reset_n_o (system_reset_n)
    );

    // Bus side logic restarts with the Apple reset
    card_bus_arbiter u_bus_arbiter (
        .clk_logic_w   (clk_logic_w),
        .arst_n_i      (system_reset_n),
        .timing        (timing_if.sink),
        .card_rd_i     (card_rd_i),
        .card_data_i   (card_data_i),
        .bus_data_i    (bus_data_i),
        .card_irq_n_i  (card_irq_n_i),
        .data_out_en_o (data_out_en_o),
        .data_out_o    (data_out_o),
        .irq_n_o       (irq_n_o)
    );

    audio_mixer u_audio_mixer (
        .clk_logic_w    (clk_logic_w),
        .arst_n_i       (system_reset_n),
        .timing         (timing_if.sink),
        .ensoniq_l_i    (ensoniq_l_i),
        .ensoniq_r_i    (ensoniq_r_i),
        .mb_l_i         (mb_l_i),
        .mb_r_i         (mb_r_i),
        .sprite_i       (sprite_i),
        .speaker_i      (speaker_i),
        .speaker_en_i   (speaker_en_i),
        .audio_l_o      (audio_l_o),
        .audio_r_o      (audio_r_o),
        .audio_strobe_o (audio_strobe_o)
    );

    assign system_reset_n_o = system_reset_n;

endmodule

`default_nettype wire

// File: design/a2_card_pkg.sv
// Card core package with the card source enum, bus and audio types, and design constants
`default_nettype none

package a2_card_pkg;

    // Read sources in priority order with the value as the bit index into the card vectors
    typedef enum logic [2:0] {
        CARD_SERIAL       = 3'd0,
        CARD_SPRITE       = 3'd1,
        CARD_MOCKINGBOARD = 3'd2,
        CARD_DISK         = 3'd3,
        CARD_ROM          = 3'd4
    } card_e;

    localparam int CARD_COUNT     = 5;
    localparam int IRQ_CARD_COUNT = 3;

    typedef logic [7:0] bus_byte_t;
    typedef logic signed [15:0] sample_t;

    // Mockingboard samples are 10 bit unsigned and get scaled up to 15 bits
    localparam int MB_SAMPLE_W = 10;
    localparam int MB_SHIFT    = 5;

    localparam int SPEAKER_LEVEL   = 'h3000;
    localparam int UNSIGNED_OFFSET = 'h8000;

    localparam int SAMPLE_MAX = 32767;
    localparam int SAMPLE_MIN = -32768;

    // Four 16 bit terms need two guard bits
    localparam int MIX_W = 18;

    // Clock input conditioning
    localparam int SYNC_STAGES   = 2;
    localparam int FILTER_STAGES = 2;

endpackage

`default_nettype wire

// File: design/audio_mixer.sv
// Converts the card audio sources to signed samples, sums with saturation once per bus cycle
`timescale 1ns/10ps
`default_nettype none

module audio_mixer (
    input  logic clk_logic_w,
    input  logic arst_n_i,
    bus_timing_if.sink timing,
    input  a2_card_pkg::sample_t ensoniq_l_i,
    input  a2_card_pkg::sample_t ensoniq_r_i,
    input  logic [a2_card_pkg::MB_SAMPLE_W-1:0] mb_l_i,
    input  logic [a2_card_pkg::MB_SAMPLE_W-1:0] mb_r_i,
    input  logic [15:0] sprite_i,
    input  logic speaker_i,
    input  logic speaker_en_i,
    output a2_card_pkg::sample_t audio_l_o,
    output a2_card_pkg::sample_t audio_r_o,
    output logic audio_strobe_o
);

    typedef logic signed [a2_card_pkg::MIX_W-1:0] mix_t;

    mix_t sprite_term;
    mix_t speaker_term;
    mix_t sum_l;
    mix_t sum_r;
    a2_card_pkg::sample_t audio_l_q;
    a2_card_pkg::sample_t audio_r_q;
    logic strobe_q;

    // Unsigned 16 bit sample made signed around zero
    function automatic mix_t from_unsigned(input logic [15:0] raw);
        return $signed({{(a2_card_pkg::MIX_W-16){1'b0}}, raw})
               - mix_t'(a2_card_pkg::UNSIGNED_OFFSET);
    endfunction

    function automatic a2_card_pkg::sample_t clamp(input mix_t sum);
        if (sum > a2_card_pkg::SAMPLE_MAX) begin
            return a2_card_pkg::sample_t'(a2_card_pkg::SAMPLE_MAX);
        end else if (sum < a2_card_pkg::SAMPLE_MIN) begin
            return a2_card_pkg::sample_t'(a2_card_pkg::SAMPLE_MIN);
        end
        return a2_card_pkg::sample_t'(sum);
    endfunction

    assign sprite_term = from_unsigned(sprite_i);

    // Speaker bit becomes a square wave of fixed amplitude
    assign speaker_term = !speaker_en_i ? mix_t'(0) :
                          speaker_i     ? mix_t'(a2_card_pkg::SPEAKER_LEVEL) :
                                          -mix_t'(a2_card_pkg::SPEAKER_LEVEL);

    assign sum_l = mix_t'(ensoniq_l_i) + sprite_term + speaker_term
                 + from_unsigned(16'(mb_l_i) << a2_card_pkg::MB_SHIFT);
    assign sum_r = mix_t'(ensoniq_r_i) + sprite_term + speaker_term
                 + from_unsigned(16'(mb_r_i) << a2_card_pkg::MB_SHIFT);

    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            audio_l_q <= '0;
            audio_r_q <= '0;
            strobe_q  <= 1'b0;
        end else begin
            strobe_q <= timing.phi1_rise;
            if (timing.phi1_rise) begin
                audio_l_q <= clamp(sum_l);
                audio_r_q <= clamp(sum_r);
            end
        end
    end

    assign audio_l_o      = audio_l_q;
    assign audio_r_o      = audio_r_q;
    assign audio_strobe_o = strobe_q;

endmodule

`default_nettype wire

// File: design/bus_clock_recovery.sv
// Recovers Phi0, Phi1 and the 7/14 MHz strobes, and combines device and Apple resets
`timescale 1ns/10ps
`default_nettype none

module bus_clock_recovery (
    input  logic clk_logic_w,
    input  logic arst_n_i,
    input  logic a2_phi1_i,
    input  logic a2_7m_i,
    input  logic a2_reset_n_i,
    bus_timing_if.source timing,
    output logic system_reset_n_o
);

    logic phi1_level;
    logic phi1_rise;
    logic phi1_fall;
    logic clk_7m_level;
    logic clk_7m_rise;
    logic clk_7m_fall;
    logic [1:0] a2_reset_sync_q;

    signal_denoise u_phi1_denoise (
        .clk_logic_w (clk_logic_w),
        .arst_n_i    (arst_n_i),
        .sig_i       (a2_phi1_i),
        .level_o     (phi1_level),
        .rise_o      (phi1_rise),
        .fall_o      (phi1_fall)
    );

    signal_denoise u_7m_denoise (
        .clk_logic_w (clk_logic_w),
        .arst_n_i    (arst_n_i),
        .sig_i       (a2_7m_i),
        .level_o     (clk_7m_level),
        .rise_o      (clk_7m_rise),
        .fall_o      (clk_7m_fall)
    );

    // Phi0 is the complement of Phi1 on the Apple bus
    assign timing.phi1           = phi1_level;
    assign timing.phi0           = ~phi1_level;
    assign timing.phi1_rise      = phi1_rise;
    assign timing.phi1_fall      = phi1_fall;
    assign timing.clk_2m_strobe  = phi1_rise | phi1_fall;
    assign timing.clk_7m         = clk_7m_level;
    assign timing.clk_14m_strobe = clk_7m_rise | clk_7m_fall;

    // Apple reset is asynchronous to the logic clock
    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            a2_reset_sync_q <= 2'b00;
        end else begin
            a2_reset_sync_q <= {a2_reset_sync_q[0], a2_reset_n_i};
        end
    end

    // Device reset asserts at once, Apple reset after the synchroniser
    assign system_reset_n_o = arst_n_i & a2_reset_sync_q[1];

endmodule

`default_nettype wire

// File: design/bus_timing_if.sv
// Recovered Apple bus clock levels and edge strobes in the logic clock domain
`timescale 1ns/10ps
`default_nettype none

interface bus_timing_if;

    logic phi0;
    logic phi1;
    logic phi1_rise;
    logic phi1_fall;
    // Pulses on either edge of the 2 MHz and 7 MHz clocks
    logic clk_2m_strobe;
    logic clk_7m;
    logic clk_14m_strobe;

    modport source (output phi0, phi1, phi1_rise, phi1_fall, clk_2m_strobe, clk_7m,
                    clk_14m_strobe);
    modport sink (input phi0, phi1, phi1_rise, phi1_fall, clk_2m_strobe, clk_7m,
                  clk_14m_strobe);

endinterface

`default_nettype wire

// File: design/card_bus_arbiter.sv
// Selects the card read byte driven onto the Apple bus and merges card interrupts
`timescale 1ns/10ps
`default_nettype none

module card_bus_arbiter (
    input  logic clk_logic_w,
    input  logic arst_n_i,
    bus_timing_if.sink timing,
    input  logic [a2_card_pkg::CARD_COUNT-1:0] card_rd_i,
    input  a2_card_pkg::bus_byte_t [a2_card_pkg::CARD_COUNT-1:0] card_data_i,
    input  a2_card_pkg::bus_byte_t bus_data_i,
    input  logic [a2_card_pkg::IRQ_CARD_COUNT-1:0] card_irq_n_i,
    output logic data_out_en_o,
    output a2_card_pkg::bus_byte_t data_out_o,
    output logic irq_n_o
);

    a2_card_pkg::card_e winner;
    logic card_hit;
    a2_card_pkg::bus_byte_t sel_data;
    a2_card_pkg::bus_byte_t data_out_q;
    logic data_out_en_q;
    logic irq_n_q;

    // Walk from lowest to highest priority so the highest asserting card wins
    always_comb begin
        winner   = a2_card_pkg::CARD_SERIAL;
        card_hit = 1'b0;
        for (int i = a2_card_pkg::CARD_COUNT - 1; i >= 0; i--) begin
            if (card_rd_i[i]) begin
                winner   = a2_card_pkg::card_e'(i);
                card_hit = 1'b1;
            end
        end
    end

    // Without a card read the bus byte is passed back unchanged
    assign sel_data = card_hit ? card_data_i[winner] : bus_data_i;

    // Enable is taken at Phi0 start and the interrupt merge on every cycle
    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_out_en_q <= 1'b0;
            irq_n_q       <= 1'b1;
        end else begin
            if (timing.phi1_fall) begin
                data_out_en_q <= card_hit;
            end
            irq_n_q <= &card_irq_n_i;
        end
    end

    // Byte is captured at Phi0 start and held for the whole bus cycle
    always_ff @(posedge clk_logic_w) begin
        if (timing.phi1_fall) begin
            data_out_q <= sel_data;
        end
    end

    assign data_out_en_o = data_out_en_q;
    assign data_out_o    = data_out_q;
    assign irq_n_o       = irq_n_q;

endmodule

`default_nettype wire

// File: design/signal_denoise.sv
// Synchroniser and glitch filter for one asynchronous clock input, with edge pulses
`timescale 1ns/10ps
`default_nettype none

module signal_denoise (
    input  logic clk_logic_w,
    input  logic arst_n_i,
    input  logic sig_i,
    output logic level_o,
    output logic rise_o,
    output logic fall_o
);

    logic [a2_card_pkg::SYNC_STAGES-1:0]   sync_q;
    logic [a2_card_pkg::FILTER_STAGES-2:0] hist_q;
    logic [a2_card_pkg::FILTER_STAGES-1:0] window;
    logic level_q;
    logic rise_q;
    logic fall_q;

    // Newest synchronised sample plus the samples held before it
    assign window = {hist_q, sync_q[a2_card_pkg::SYNC_STAGES-1]};

    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_q  <= '0;
            hist_q  <= '0;
            level_q <= 1'b0;
            rise_q  <= 1'b0;
            fall_q  <= 1'b0;
        end else begin
            sync_q <= {sync_q[a2_card_pkg::SYNC_STAGES-2:0], sig_i};
            hist_q <= window[a2_card_pkg::FILTER_STAGES-2:0];
            rise_q <= 1'b0;
            fall_q <= 1'b0;
            // Level only flips once the whole window agrees on the new value
            if (!level_q && (&window)) begin
                level_q <= 1'b1;
                rise_q  <= 1'b1;
            end else if (level_q && !(|window)) begin
                level_q <= 1'b0;
                fall_q  <= 1'b1;
            end
        end
    end

    assign level_o = level_q;
    assign rise_o  = rise_q;
    assign fall_o  = fall_q;

endmodule

`default_nettype wire

// File: test/tb_tasks.svh
// Directed test tasks and result checks for the card core testbench

task automatic report_mismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
    error_count++;
endtask

// Inputs change a short delay after the rising edge
task automatic step_to_drive();
    @(posedge clk_logic_w);
    #1;
endtask

task automatic wait_audio_strobe();
    int waited;
    waited = 0;
    @(negedge clk_logic_w);
    while (audio_strobe_o !== 1'b1 && waited < STROBE_LIMIT) begin
        @(negedge clk_logic_w);
        waited++;
    end
    if (audio_strobe_o !== 1'b1) begin
        $display("No audio_strobe_o arrived within %0d cycles at %0t", STROBE_LIMIT, $time);
        error_count++;
    end
endtask

// Ends half way through the Phi0 phase after the byte capture
task automatic wait_phi0_middle();
    int waited;
    waited = 0;
    while (a2_phi1_i !== 1'b0 && waited < BUS_CYCLE) begin
        @(negedge clk_logic_w);
        waited++;
    end
    repeat (PHI1_HALF / 2) @(negedge clk_logic_w);
endtask

task automatic check_idle_outputs();
    if (data_out_en_o !== 1'b0) report_mismatch("data_out_en_o", 1'b0, data_out_en_o);
    if (irq_n_o !== 1'b1) report_mismatch("irq_n_o", 1'b1, irq_n_o);
    if (audio_strobe_o !== 1'b0) report_mismatch("audio_strobe_o", 1'b0, audio_strobe_o);
endtask

task automatic expect_reset_level(input logic level, input string cause);
    bit seen;
    seen = 1'b0;
    repeat (3) begin
        @(negedge clk_logic_w);
        if (system_reset_n_o === level) seen = 1'b1;
    end
    if (!seen) begin
        $display("system_reset_n_o did not reach %0b within 3 cycles %s", level, cause);
        error_count++;
    end
endtask

task automatic test_reset();
    repeat (RESET_CYCLES) begin
        @(negedge clk_logic_w);
        check_idle_outputs();
    end
    step_to_drive();
    arst_n_i = 1'b1;
    expect_reset_level(1'b1, "after device reset release");
    check_idle_outputs();
    step_to_drive();
    a2_reset_n_i = 1'b0;
    expect_reset_level(1'b0, "after Apple reset assertion");
    check_idle_outputs();
    step_to_drive();
    a2_reset_n_i = 1'b1;
    expect_reset_level(1'b1, "after Apple reset release");
endtask

// Lowest card index has the highest priority
function automatic logic [7:0] predict_read_byte(input logic [4:0] rd, input logic [39:0] data,
                                                 input logic [7:0] bus);
    logic [7:0] predicted;
    bit found;
    predicted = bus;
    found     = 1'b0;
    for (int idx = 0; idx < a2_card_pkg::CARD_COUNT; idx++) begin
        if (rd[idx] && !found) begin
            predicted = data[idx*8 +: 8];
            found     = 1'b1;
        end
    end
    return predicted;
endfunction

task automatic test_priority();
    logic [7:0] expected;
    logic expected_en;
    wait_audio_strobe();
    for (int round = 0; round < PRIO_ROUNDS; round++) begin
        step_to_drive();
        card_rd_i   = (round % 4 == 3) ? 5'b00000 : 5'($random(seed));
        card_data_i = 40'({$random(seed), $random(seed)});
        bus_data_i  = 8'($random(seed));
        expected    = predict_read_byte(card_rd_i, card_data_i, bus_data_i);
        expected_en = (card_rd_i != 5'b00000);
        wait_audio_strobe();
        if (data_out_o !== expected) report_mismatch("data_out_o", expected, data_out_o);
        if (data_out_en_o !== expected_en) begin
            report_mismatch("data_out_en_o", expected_en, data_out_en_o);
        end
    end
endtask

task automatic test_hold();
    logic [7:0] first_byte;
    logic [7:0] second_byte;
    wait_audio_strobe();
    step_to_drive();
    first_byte  = 8'($random(seed));
    second_byte = ~first_byte;
    card_rd_i   = 5'b01000;
    card_data_i = {8'h00, first_byte, 24'h000000};
    wait_phi0_middle();
    step_to_drive();
    card_data_i[31:24] = second_byte;
    wait_audio_strobe();
    if (data_out_o !== first_byte) report_mismatch("data_out_o", first_byte, data_out_o);
    wait_audio_strobe();
    if (data_out_o !== second_byte) report_mismatch("data_out_o", second_byte, data_out_o);
endtask

task automatic test_irq_merge();
    logic expected;
    for (int idx = 0; idx < 16; idx++) begin
        step_to_drive();
        card_irq_n_i = (idx < 8) ? 3'(idx) : 3'($random(seed));
        expected     = (card_irq_n_i == 3'b111);
        repeat (2) @(negedge clk_logic_w);
        if (irq_n_o !== expected) report_mismatch("irq_n_o", expected, irq_n_o);
    end
    step_to_drive();
    card_irq_n_i = '1;
endtask

function automatic logic [15:0] expected_mix(input logic [15:0] ensoniq, input logic [9:0] mb,
                                             input logic [15:0] sprite, input logic spk,
                                             input logic spk_en);
    int total;
    total = int'($signed(ensoniq)) + (int'(mb) << a2_card_pkg::MB_SHIFT)
          - a2_card_pkg::UNSIGNED_OFFSET + int'(sprite) - a2_card_pkg::UNSIGNED_OFFSET;
    if (spk_en && spk) total = total + a2_card_pkg::SPEAKER_LEVEL;
    if (spk_en && !spk) total = total - a2_card_pkg::SPEAKER_LEVEL;
    if (total > a2_card_pkg::SAMPLE_MAX) total = a2_card_pkg::SAMPLE_MAX;
    if (total < a2_card_pkg::SAMPLE_MIN) total = a2_card_pkg::SAMPLE_MIN;
    return 16'(total);
endfunction

task automatic run_audio_case(input logic [15:0] ens_l, input logic [15:0] ens_r,
                              input logic [9:0] mb_l, input logic [9:0] mb_r,
                              input logic [15:0] sprite, input logic spk, input logic spk_en);
    logic [15:0] exp_l;
    logic [15:0] exp_r;
    step_to_drive();
    ensoniq_l_i  = ens_l;
    ensoniq_r_i  = ens_r;
    mb_l_i       = mb_l;
    mb_r_i       = mb_r;
    sprite_i     = sprite;
    speaker_i    = spk;
    speaker_en_i = spk_en;
    exp_l        = expected_mix(ens_l, mb_l, sprite, spk, spk_en);
    exp_r        = expected_mix(ens_r, mb_r, sprite, spk, spk_en);
    wait_audio_strobe();
    if (audio_l_o !== exp_l) report_mismatch("audio_l_o", exp_l, audio_l_o);
    if (audio_r_o !== exp_r) report_mismatch("audio_r_o", exp_r, audio_r_o);
endtask

task automatic test_audio();
    wait_audio_strobe();
    // Both saturation limits and then an in-range mix with speaker on and off
    run_audio_case(16'h7FFF, 16'h7FFF, 10'h3FF, 10'h3FF, 16'hFFFF, 1'b1, 1'b1);
    run_audio_case(16'h8000, 16'h8000, 10'h000, 10'h000, 16'h0000, 1'b0, 1'b1);
    run_audio_case(16'h1234, 16'hFF00, 10'h3FF, 10'h200, 16'h8000, 1'b1, 1'b1);
    run_audio_case(16'h1234, 16'hFF00, 10'h3FF, 10'h200, 16'h8000, 1'b1, 1'b0);
    repeat (AUDIO_ROUNDS) begin
        run_audio_case(16'($random(seed)), 16'($random(seed)), 10'($random(seed)),
                       10'($random(seed)), 16'($random(seed)), 1'($random(seed)),
                       1'($random(seed)));
    end
endtask

// A one cycle low pulse inside Phi1 must not look like a bus clock edge
task automatic test_glitch();
    logic [7:0] held_byte;
    wait_audio_strobe();
    held_byte = data_out_o;
    step_to_drive();
    card_rd_i  = '0;
    bus_data_i = ~held_byte;
    repeat (2) step_to_drive();
    phi1_glitch = 1'b1;
    step_to_drive();
    phi1_glitch = 1'b0;
    repeat (10) begin
        @(negedge clk_logic_w);
        if (audio_strobe_o !== 1'b0) report_mismatch("audio_strobe_o", 1'b0, audio_strobe_o);
        if (data_out_o !== held_byte) report_mismatch("data_out_o", held_byte, data_out_o);
    end
endtask

// File: test/tb_a2_card_core.sv
// Testbench for the card core with bus clock generators, directed tests and a watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_a2_card_core;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 3;
    localparam int PHI1_HALF    = 20;
    localparam int CLK_7M_HALF  = 6;
    localparam int BUS_CYCLE    = 2 * PHI1_HALF;
    localparam int STROBE_LIMIT = BUS_CYCLE + 10;
    localparam int PRIO_ROUNDS  = 12;
    localparam int AUDIO_ROUNDS = 12;
    // Every test takes a few bus cycles beyond its rounds
    localparam int TEST_CYCLES  = (PRIO_ROUNDS + AUDIO_ROUNDS + 20) * BUS_CYCLE;

    logic clk_logic_w;
    logic arst_n_i;
    logic phi1_gen;
    logic phi1_glitch;
    logic a2_phi1_i;
    logic a2_7m_i;
    logic a2_reset_n_i;
    logic [4:0] card_rd_i;
    logic [39:0] card_data_i;
    logic [7:0] bus_data_i;
    logic [2:0] card_irq_n_i;
    logic [15:0] ensoniq_l_i;
    logic [15:0] ensoniq_r_i;
    logic [9:0] mb_l_i;
    logic [9:0] mb_r_i;
    logic [15:0] sprite_i;
    logic speaker_i;
    logic speaker_en_i;
    logic system_reset_n_o;
    logic data_out_en_o;
    logic [7:0] data_out_o;
    logic irq_n_o;
    logic [15:0] audio_l_o;
    logic [15:0] audio_r_o;
    logic audio_strobe_o;
    integer seed;
    int error_count;

    assign a2_phi1_i = phi1_gen ^ phi1_glitch;

    a2_card_core UUT (
        .clk_logic_w      (clk_logic_w),
        .arst_n_i         (arst_n_i),
        .a2_phi1_i        (a2_phi1_i),
        .a2_7m_i          (a2_7m_i),
        .a2_reset_n_i     (a2_reset_n_i),
        .card_rd_i        (card_rd_i),
        .card_data_i      (card_data_i),
        .bus_data_i       (bus_data_i),
        .card_irq_n_i     (card_irq_n_i),
        .ensoniq_l_i      (ensoniq_l_i),
        .ensoniq_r_i      (ensoniq_r_i),
        .mb_l_i           (mb_l_i),
        .mb_r_i           (mb_r_i),
        .sprite_i         (sprite_i),
        .speaker_i        (speaker_i),
        .speaker_en_i     (speaker_en_i),
        .system_reset_n_o (system_reset_n_o),
        .data_out_en_o    (data_out_en_o),
        .data_out_o       (data_out_o),
        .irq_n_o          (irq_n_o),
        .audio_l_o        (audio_l_o),
        .audio_r_o        (audio_r_o),
        .audio_strobe_o   (audio_strobe_o)
    );

    `include "tb_tasks.svh"

    initial begin
        clk_logic_w = 1'b0;
        forever #(CLK_PERIOD / 2) clk_logic_w = ~clk_logic_w;
    end

    // Apple bus Phi1 runs freely from time zero
    initial begin
        phi1_gen = 1'b0;
        forever begin
            repeat (PHI1_HALF) @(posedge clk_logic_w);
            #1;
            phi1_gen = ~phi1_gen;
        end
    end

    initial begin
        a2_7m_i = 1'b0;
        forever begin
            repeat (CLK_7M_HALF) @(posedge clk_logic_w);
            #1;
            a2_7m_i = ~a2_7m_i;
        end
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the tests finished", TEST_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        seed         = 32'h40df948d;
        error_count  = 0;
        phi1_glitch  = 1'b0;
        arst_n_i     = 1'b0;
        a2_reset_n_i = 1'b1;
        card_rd_i    = '0;
        card_data_i  = '0;
        bus_data_i   = '0;
        card_irq_n_i = '1;
        ensoniq_l_i  = '0;
        ensoniq_r_i  = '0;
        mb_l_i       = '0;
        mb_r_i       = '0;
        sprite_i     = 16'h8000;
        speaker_i    = 1'b0;
        speaker_en_i = 1'b0;
        test_reset();
        test_priority();
        test_hold();
        test_irq_merge();
        test_audio();
        test_glitch();
        $display("Tests finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
